/* rtl/flash_cmd_pkg.sv */
package flash_cmd_pkg;

	//--------------------------------------------------------------------------
	// flash side widths
	typedef logic [23:0] flash_addr_t;	// byte address into the array
	typedef logic [31:0] flash_word_t;	// lowest address sits in bits 7..0
	typedef logic [7:0]  flash_byte_t;	// one byte on the wire

	//--------------------------------------------------------------------------
	// serial NOR opcodes
	localparam flash_byte_t OP_RESET   = 8'hF0;	// issued once after rst
	localparam flash_byte_t OP_READ    = 8'h03;	// plain read
	localparam flash_byte_t OP_WREN    = 8'h06;	// sets write enable latch
	localparam flash_byte_t OP_PROGRAM = 8'h02;	// page program
	localparam flash_byte_t OP_ERASE   = 8'hD8;	// sector erase
	localparam flash_byte_t OP_RDSR    = 8'h05;	// read status register

	localparam int ADDR_BYTES      = 3;	// 24 bit address msb first
	localparam int WORD_BYTES      = 4;	// one bus word per command
	localparam int STATUS_BUSY_BIT = 0;	// write in progress

	// what the bus front end asks for
	typedef enum logic [1:0] {
		CMD_READ    = 2'd0,
		CMD_PROGRAM = 2'd1,
		CMD_ERASE   = 2'd2
	} cmd_kind_e;

	typedef struct packed {
		cmd_kind_e   kind;	// read / program / erase
		flash_addr_t addr;	// sector address for erase
		flash_word_t wdata;	// only used by program
	} cmd_req_t;	// 58 bits

endpackage

/* rtl/spi_link_pkg.sv */
package spi_link_pkg;

	//--------------------------------------------------------------------------
	// byte level link between sequencer and shifter
	typedef logic [7:0] link_byte_t;	// one byte on MOSI or MISO
	typedef logic [7:0] sck_div_t;	// clk cycles per SCK half-period

	// request into the shifter holding register
	typedef struct packed {
		link_byte_t tx;	// shifted out msb first
		logic       capture;	// hand the received byte back
		logic       last;	// cs_n goes high after this byte
	} byte_req_t;	// 10 bits

	// one per captured byte, in order
	typedef struct packed {
		link_byte_t rx;	// sampled on rising SCK
	} byte_rsp_t;	// 8 bits

endpackage

/* rtl/wb_flash_slave.sv */
`timescale 1ns/100ps

module wb_flash_slave import flash_cmd_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	// wishbone classic slave
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [25:0] adr_i,
	input  flash_word_t dat_i,
	output flash_word_t dat_o,
	output logic        ack_o,
	// command channel to the sequencer
	output logic        cmd_valid_o,
	input  logic        cmd_ready_i,
	output cmd_req_t    cmd_o,
	input  logic        cmd_done_i,
	input  flash_word_t rd_word_i
);

	logic        req;	// live bus cycle
	logic        hit_mem;	// region 0 array access
	logic        hit_erase;	// region 1 write
	logic        hit_flash;	// needs a flash command
	logic        miss;	// anything else gets acked at once
	logic        issued_q;	// command already sent for this cycle
	logic        ack_q;
	flash_word_t dat_q;	// read data held for the master

	assign req       = cyc_i & stb_i;
	assign hit_mem   = adr_i[25:24] == 2'd0;
	assign hit_erase = (adr_i[25:24] == 2'd1) & we_i;
	assign hit_flash = hit_mem | hit_erase;
	assign miss      = req & ~hit_flash & ~ack_q;	// one ack per cycle

	//--------------------------------------------------------------------------
	// decode into one command
	assign cmd_o = '{
		kind:  hit_erase ? CMD_ERASE : (we_i ? CMD_PROGRAM : CMD_READ),
		addr:  adr_i[23:0],	// byte selects ignored
		wdata: dat_i
	};

	// offered only while the sequencer sits in idle
	assign cmd_valid_o = req & hit_flash & ~issued_q & cmd_ready_i;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			issued_q <= 1'b0;
			ack_q    <= 1'b0;
		end else begin
			ack_q <= cmd_done_i | miss;	// single cycle pulse
			if (ack_q)
				issued_q <= 1'b0;	// master drops stb after this
			else if (cmd_valid_o)
				issued_q <= 1'b1;	// cmd_ready already folded in
		end
	end

	// read word or zero for the unmapped regions
	always_ff @(posedge clk) begin
		if (cmd_done_i)
			dat_q <= rd_word_i;
		else if (miss)
			dat_q <= '0;
	end

	assign ack_o = ack_q;
	assign dat_o = dat_q;

endmodule

/* rtl/flash_cmd_sequencer.sv */
`timescale 1ns/100ps

module flash_cmd_sequencer import flash_cmd_pkg::*, spi_link_pkg::*; #(
	parameter int unsigned RESET_WAIT = 20	// settle cycles after OP_RESET
) (
	input  logic        clk,
	input  logic        rst,
	// from the bus front end
	input  logic        cmd_valid_i,
	output logic        cmd_ready_o,
	input  cmd_req_t    cmd_i,
	output logic        cmd_done_o,
	output flash_word_t rd_word_o,
	// to the byte shifter
	output logic        byte_valid_o,
	input  logic        byte_ready_i,
	output byte_req_t   byte_o,
	input  logic        rsp_valid_i,
	input  byte_rsp_t   rsp_i
);

	localparam int WAIT_W = $clog2(RESET_WAIT + 2);

	typedef enum logic [3:0] {
		S_BOOT,	// one cycle out of reset
		S_RST_OP,	// reset opcode
		S_RST_END,
		S_SETTLE,	// device recovery time
		S_IDLE,
		S_WREN,	// write enable before program / erase
		S_WREN_END,
		S_OPCODE,
		S_ADDR,	// three address bytes
		S_DATA,	// four data bytes
		S_XFER_END,	// wait for cs_n release
		S_POLL_OP,	// RDSR opcode
		S_POLL_RD,	// status byte
		S_POLL_END
	} seq_state_e;

	seq_state_e        state_q;
	cmd_req_t          cmd_q;	// latched command
	logic [1:0]        cnt_q;	// address or data byte index
	logic [2:0]        pend_q;	// captured bytes not yet answered
	logic [WAIT_W-1:0] wait_q;
	logic              done_q;
	flash_word_t       rd_word_q;
	logic              accept;
	logic              cap_acc;	// accepted byte will send a response
	logic              xfer_end;
	logic              is_read;
	logic              last_addr;
	logic              last_data;
	flash_byte_t       opcode;

	assign is_read   = cmd_q.kind == CMD_READ;
	assign last_addr = cnt_q == 2'(ADDR_BYTES - 1);
	assign last_data = cnt_q == 2'(WORD_BYTES - 1);
	assign accept    = byte_valid_o & byte_ready_i;
	assign cap_acc   = accept & byte_o.capture;
	assign xfer_end  = rsp_valid_i && pend_q == 3'd1;	// answer to the last byte

	always_comb begin
		case (cmd_q.kind)
			CMD_READ:    opcode = OP_READ;
			CMD_PROGRAM: opcode = OP_PROGRAM;
			default:     opcode = OP_ERASE;
		endcase
	end

	//--------------------------------------------------------------------------
	// byte request per state; every last byte carries capture
	always_comb begin
		byte_valid_o = 1'b1;
		byte_o       = '{tx: 8'h00, capture: 1'b0, last: 1'b0};
		case (state_q)
			S_RST_OP:  byte_o = '{tx: OP_RESET, capture: 1'b1, last: 1'b1};
			S_WREN:    byte_o = '{tx: OP_WREN, capture: 1'b1, last: 1'b1};
			S_OPCODE:  byte_o.tx = opcode;
			S_ADDR: begin
				byte_o.tx      = cmd_q.addr[8 * (ADDR_BYTES - 1 - int'(cnt_q)) +: 8];
				byte_o.capture = last_addr & (cmd_q.kind == CMD_ERASE);	// erase ends here
				byte_o.last    = last_addr & (cmd_q.kind == CMD_ERASE);
			end
			S_DATA: begin
				byte_o.tx      = is_read ? 8'h00 : cmd_q.wdata[8 * cnt_q +: 8];	// low byte first
				byte_o.capture = is_read | last_data;
				byte_o.last    = last_data;
			end
			S_POLL_OP: byte_o.tx = OP_RDSR;
			S_POLL_RD: byte_o = '{tx: 8'h00, capture: 1'b1, last: 1'b1};
			default:   byte_valid_o = 1'b0;	// waiting states
		endcase
	end

	//--------------------------------------------------------------------------
	// main FSM
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q <= S_BOOT;
			cnt_q   <= '0;
			pend_q  <= '0;
			wait_q  <= '0;
			done_q  <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (cap_acc && !rsp_valid_i)
				pend_q <= pend_q + 3'd1;
			else if (rsp_valid_i && !cap_acc)
				pend_q <= pend_q - 3'd1;
			case (state_q)
				S_BOOT: state_q <= S_RST_OP;
				S_RST_OP: begin
					if (accept)
						state_q <= S_RST_END;
				end
				S_RST_END: begin
					if (xfer_end) begin
						wait_q  <= '0;
						state_q <= S_SETTLE;
					end
				end
				S_SETTLE: begin
					if (wait_q == WAIT_W'(RESET_WAIT - 1))
						state_q <= S_IDLE;	// cmd_ready rises here
					else
						wait_q <= wait_q + 1'b1;
				end
				S_IDLE: begin
					if (cmd_valid_i)
						state_q <= (cmd_i.kind == CMD_READ) ? S_OPCODE : S_WREN;
				end
				S_WREN: begin
					if (accept)
						state_q <= S_WREN_END;
				end
				S_WREN_END: begin
					if (xfer_end)
						state_q <= S_OPCODE;	// new transaction after guard
				end
				S_OPCODE: begin
					if (accept) begin
						cnt_q   <= '0;
						state_q <= S_ADDR;
					end
				end
				S_ADDR: begin
					if (accept && last_addr) begin
						cnt_q   <= '0;
						state_q <= (cmd_q.kind == CMD_ERASE) ? S_XFER_END : S_DATA;
					end else if (accept) begin
						cnt_q <= cnt_q + 2'd1;
					end
				end
				S_DATA: begin
					if (accept && last_data) begin
						cnt_q   <= '0;
						state_q <= S_XFER_END;
					end else if (accept) begin
						cnt_q <= cnt_q + 2'd1;
					end
				end
				S_XFER_END: begin
					if (xfer_end && is_read) begin
						done_q  <= 1'b1;	// rd_word complete at the same edge
						state_q <= S_IDLE;
					end else if (xfer_end) begin
						state_q <= S_POLL_OP;	// program / erase still running
					end
				end
				S_POLL_OP: begin
					if (accept)
						state_q <= S_POLL_RD;
				end
				S_POLL_RD: begin
					if (accept)
						state_q <= S_POLL_END;
				end
				S_POLL_END: begin
					if (xfer_end && rsp_i.rx[STATUS_BUSY_BIT]) begin
						state_q <= S_POLL_OP;	// busy so poll again
					end else if (xfer_end) begin
						done_q  <= 1'b1;
						state_q <= S_IDLE;
					end
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	// command latch and read word assembly
	always_ff @(posedge clk) begin
		if (cmd_valid_i && cmd_ready_o)
			cmd_q <= cmd_i;
		if (rsp_valid_i)
			rd_word_q <= {rsp_i.rx, rd_word_q[31:8]};	// first byte ends in 7..0
	end

	assign cmd_ready_o = state_q == S_IDLE;
	assign cmd_done_o  = done_q;
	assign rd_word_o   = rd_word_q;

endmodule

/* rtl/spi_byte_shifter.sv */
`timescale 1ns/100ps

module spi_byte_shifter import spi_link_pkg::*; #(
	parameter sck_div_t SCK_DIV = 8'd2	// clk cycles per SCK half-period
) (
	input  logic      clk,
	input  logic      rst,
	input  logic      byte_valid_i,
	output logic      byte_ready_o,
	input  byte_req_t byte_i,
	output logic      rsp_valid_o,
	output byte_rsp_t rsp_o,
	// SPI mode 0 pins
	output logic      sck_o,
	output logic      cs_n_o,
	output logic      mosi_o,
	input  logic      miso_i
);

	typedef enum logic [1:0] {
		SH_IDLE,	// cs_n high and guard over
		SH_SHIFT,	// byte on the wire
		SH_STALL,	// cs_n low with nothing to send
		SH_GUARD	// cs_n high minimum time
	} sh_state_e;

	sh_state_e  state_q;
	sck_div_t   div_q;	// half-period counter
	logic [2:0] bit_q;
	link_byte_t shift_q;	// msb drives mosi
	link_byte_t rx_q;
	byte_req_t  hold_q;	// holding register
	logic       hold_valid_q;
	logic       cur_cap_q;
	logic       cur_last_q;
	logic       guard_q;	// first guard half done
	logic       sck_q;
	logic       cs_n_q;
	logic       rsp_valid_q;
	byte_rsp_t  rsp_q;
	logic       tick, rise, fall, byte_end, start, chain;

	assign tick     = div_q == SCK_DIV - 8'd1;
	assign rise     = (state_q == SH_SHIFT) & tick & ~sck_q;	// sample miso
	assign fall     = (state_q == SH_SHIFT) & tick & sck_q;	// next mosi bit
	assign byte_end = fall & (bit_q == 3'd7);
	assign start    = hold_valid_q & (state_q == SH_IDLE || state_q == SH_STALL);
	assign chain    = byte_end & hold_valid_q & ~cur_last_q;	// back to back

	assign byte_ready_o = ~hold_valid_q;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state_q      <= SH_IDLE;
			div_q        <= '0;
			bit_q        <= '0;
			shift_q      <= '0;
			hold_valid_q <= 1'b0;
			cur_cap_q    <= 1'b0;
			cur_last_q   <= 1'b0;
			guard_q      <= 1'b0;
			sck_q        <= 1'b0;
			cs_n_q       <= 1'b1;
			rsp_valid_q  <= 1'b0;
		end else begin
			rsp_valid_q <= byte_end & cur_cap_q;
			if (start || chain)
				hold_valid_q <= 1'b0;
			else if (byte_valid_i && byte_ready_o)
				hold_valid_q <= 1'b1;
			case (state_q)
				SH_SHIFT: begin
					div_q <= tick ? '0 : div_q + 8'd1;
					if (rise)
						sck_q <= 1'b1;
					if (fall && !byte_end) begin
						sck_q   <= 1'b0;
						shift_q <= {shift_q[6:0], 1'b0};
						bit_q   <= bit_q + 3'd1;
					end else if (byte_end && cur_last_q) begin
						sck_q   <= 1'b0;
						cs_n_q  <= 1'b1;	// end of transaction
						guard_q <= 1'b0;
						state_q <= SH_GUARD;
					end else if (byte_end) begin
						sck_q <= 1'b0;
						if (!hold_valid_q)
							state_q <= SH_STALL;	// keep cs_n low
					end
				end
				SH_GUARD: begin
					div_q <= tick ? '0 : div_q + 8'd1;
					if (tick) begin
						guard_q <= 1'b1;
						if (guard_q)
							state_q <= SH_IDLE;	// 2 x SCK_DIV elapsed
					end
				end
				default: ;	// idle and stall wait for start
			endcase
			// load from the holding register
			if (start || chain) begin
				shift_q    <= hold_q.tx;
				cur_cap_q  <= hold_q.capture;
				cur_last_q <= hold_q.last;
				bit_q      <= '0;
				div_q      <= '0;
				cs_n_q     <= 1'b0;
				state_q    <= SH_SHIFT;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (byte_valid_i && byte_ready_o)
			hold_q <= byte_i;
		if (rise)
			rx_q <= {rx_q[6:0], miso_i};	// msb first
		if (byte_end)
			rsp_q.rx <= rx_q;
	end

	assign sck_o       = sck_q;
	assign cs_n_o      = cs_n_q;
	assign mosi_o      = shift_q[7];
	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

endmodule

/* rtl/spi_flash_ctrl.sv */
`timescale 1ns/100ps

module spi_flash_ctrl import flash_cmd_pkg::*, spi_link_pkg::*; #(
	parameter sck_div_t    SCK_DIV    = 8'd2,	// SCK half-period in clk cycles
	parameter int unsigned RESET_WAIT = 20	// settle after reset opcode
) (
	input  logic        clk,
	input  logic        rst,
	// wishbone classic slave
	input  logic        cyc_i,
	input  logic        stb_i,
	input  logic        we_i,
	input  logic [25:0] adr_i,
	input  flash_word_t dat_i,
	output flash_word_t dat_o,
	output logic        ack_o,
	// serial flash pins
	output logic        sck_o,
	output logic        cs_n_o,
	output logic        mosi_o,
	input  logic        miso_i
);

	//--------------------------------------------------------------------------
	// stage links
	logic        cmd_valid, cmd_ready, cmd_done;
	cmd_req_t    cmd;
	flash_word_t rd_word;
	logic        byte_valid, byte_ready, rsp_valid;
	byte_req_t   byte_req;
	byte_rsp_t   rsp;

	wb_flash_slave i_wb_flash_slave (
		.clk, .rst, .cyc_i, .stb_i, .we_i, .adr_i, .dat_i, .dat_o, .ack_o,
		.cmd_valid_o (cmd_valid),
		.cmd_ready_i (cmd_ready),
		.cmd_o       (cmd),
		.cmd_done_i  (cmd_done),
		.rd_word_i   (rd_word)
	);

	flash_cmd_sequencer #(.RESET_WAIT(RESET_WAIT)) i_flash_cmd_sequencer (
		.clk, .rst,
		.cmd_valid_i  (cmd_valid),
		.cmd_ready_o  (cmd_ready),
		.cmd_i        (cmd),
		.cmd_done_o   (cmd_done),
		.rd_word_o    (rd_word),
		.byte_valid_o (byte_valid),
		.byte_ready_i (byte_ready),
		.byte_o       (byte_req),
		.rsp_valid_i  (rsp_valid),
		.rsp_i        (rsp)
	);

	spi_byte_shifter #(.SCK_DIV(SCK_DIV)) i_spi_byte_shifter (
		.clk, .rst,
		.byte_valid_i (byte_valid),
		.byte_ready_o (byte_ready),
		.byte_i       (byte_req),
		.rsp_valid_o  (rsp_valid),
		.rsp_o        (rsp),
		.sck_o, .cs_n_o, .mosi_o, .miso_i
	);

endmodule

/* sim/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen #(
	parameter int PERIOD_NS  = 4,	// clk period
	parameter int RST_CYCLES = 10	// rst held for this many edges
) (
	output logic clk_o = 1'b0,
	output logic rst_o = 1'b1
);

	initial forever #(PERIOD_NS / 2) clk_o = ~clk_o;

	initial begin
		repeat (RST_CYCLES) @(posedge clk_o);
		rst_o <= 1'b0;	// released on a rising edge
	end

endmodule

/* sim/spi_flash_model.sv */
`timescale 1ns/100ps

module spi_flash_model import flash_cmd_pkg::*; #(
	parameter int BUSY_POLLS = 3	// RDSR transactions that report busy
) (
	input  logic sck_i,
	input  logic cs_n_i,
	input  logic mosi_i,
	output logic miso_o = 1'b0,
	output int   reset_cnt_o,	// OP_RESET opcodes seen
	output int   wren_viol_o,	// program / erase without write enable
	output logic busy_o
);

	flash_byte_t mem [256];	// filled by the testbench at time 0
	logic [2:0]  bit_cnt = '0;
	int          byte_idx = 0;	// byte position inside the transaction
	flash_byte_t shreg = '0;
	flash_byte_t opcode = '0;
	flash_byte_t out_q = '0;	// next byte for miso
	flash_addr_t addr = '0;
	logic        wel = 1'b0;	// write enable latch
	logic        armed = 1'b0;	// current program / erase may act
	int          busy_cnt = 0;
	int          reset_cnt = 0;
	int          wren_viol = 0;

	//--------------------------------------------------------------------------
	// mosi sampled on rising SCK, whole bytes decoded here
	always @(posedge sck_i or posedge cs_n_i) begin : rx_bit
		flash_byte_t rx;
		if (cs_n_i) begin
			bit_cnt  = '0;	// next transaction starts at opcode
			byte_idx = 0;
		end else begin
			rx      = {shreg[6:0], mosi_i};	// msb first
			shreg   = rx;
			bit_cnt = bit_cnt + 3'd1;
			if (bit_cnt == 3'd0) begin
				if (byte_idx == 0) begin
					opcode = rx;
					case (rx)
						OP_RESET: reset_cnt++;
						OP_WREN:  wel = 1'b1;
						OP_RDSR: begin
							out_q = {6'b0, wel, busy_cnt != 0};	// busy in bit 0
							if (busy_cnt != 0)
								busy_cnt--;
						end
						OP_PROGRAM, OP_ERASE: begin
							armed = wel;
							if (!wel)
								wren_viol++;
							else
								busy_cnt = BUSY_POLLS;
							wel = 1'b0;	// latch cleared either way
						end
						default: ;
					endcase
				end else if (byte_idx <= ADDR_BYTES) begin
					addr = {addr[15:0], rx};	// address msb first
					if (byte_idx == ADDR_BYTES && opcode == OP_READ)
						out_q = mem[addr[7:0]];
					if (byte_idx == ADDR_BYTES && opcode == OP_ERASE && armed)
						for (int k = 0; k < 256; k++)
							mem[8'(k)] = 8'hFF;	// whole array is one sector
				end else if (opcode == OP_READ) begin
					out_q = mem[addr[7:0] + 8'(byte_idx - ADDR_BYTES)];
				end else if (opcode == OP_PROGRAM && armed) begin
					mem[addr[7:0] + 8'(byte_idx - ADDR_BYTES - 1)] = rx;
				end
				byte_idx++;
			end
		end
	end

	// miso moves on falling SCK, ahead of the next sample
	always @(negedge sck_i)
		miso_o <= out_q[~bit_cnt];

	assign reset_cnt_o = reset_cnt;
	assign wren_viol_o = wren_viol;
	assign busy_o      = busy_cnt != 0;

endmodule

/* sim/spi_flash_ctrl_properties.sv */
`timescale 1ns/100ps

module spi_flash_ctrl_properties (
	input logic clk,
	input logic rst,
	input logic cyc_i,
	input logic stb_i,
	input logic ack_i,
	input logic sck_i,
	input logic cs_n_i,
	input logic mosi_i,
	input logic cmd_valid_i,
	input logic seq_idle_i	// sequencer sits in idle
);

	//--------------------------------------------------------------------------
	// wishbone side
	ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		ack_i |-> cyc_i && stb_i)
		else $error("ack_o high outside a bus cycle");

	ack_single: assert property (@(posedge clk) disable iff (rst)
		ack_i |=> !ack_i)
		else $error("ack_o high for two cycles in a row");

	cmd_taken: assert property (@(posedge clk) disable iff (rst)
		cmd_valid_i |=> !seq_idle_i)	// offered in idle, busy right after
		else $error("command offered to the sequencer was not taken");

	//--------------------------------------------------------------------------
	// SPI pins
	sck_idle_low: assert property (@(posedge clk) disable iff (rst)
		cs_n_i |-> !sck_i)
		else $error("sck_o high while cs_n_o is high");

	mosi_hold: assert property (@(posedge clk) disable iff (rst)
		sck_i |-> $stable(mosi_i))
		else $error("mosi_o changed while sck_o was high");

endmodule

bind spi_flash_ctrl spi_flash_ctrl_properties i_spi_flash_ctrl_properties (
	.clk         (clk),
	.rst         (rst),
	.cyc_i       (cyc_i),
	.stb_i       (stb_i),
	.ack_i       (ack_o),
	.sck_i       (sck_o),
	.cs_n_i      (cs_n_o),
	.mosi_i      (mosi_o),
	.cmd_valid_i (cmd_valid),
	.seq_idle_i  (cmd_ready)
);

/* sim/tb_spi_flash_ctrl.sv */
`timescale 1ns/100ps

module tb_spi_flash_ctrl import flash_cmd_pkg::*; ();

	localparam logic [31:0] LFSR_SEED = 32'h9575c0bc;
	localparam int N_CMDS         = 12;	// commands issued below, rounded up
	localparam int CMD_MAX_CYCLES = 2000;	// worst program with polling
	localparam int TIMEOUT_CYCLES = N_CMDS * CMD_MAX_CYCLES + 16000;	// reset and margin

	logic        clk, rst;
	logic        cyc = 1'b0;
	logic        stb = 1'b0;
	logic        we = 1'b0;
	logic [25:0] adr = '0;
	flash_word_t dat_w = '0;
	flash_word_t dat_o;
	logic        ack_o, sck_o, cs_n_o, mosi_o, miso_i;
	int          reset_cnt, wren_viol;
	logic        flash_busy;
	logic        unmapped;	// cycle that must not touch the flash
	flash_byte_t ref_mem [256];	// expected flash contents
	logic [31:0] lfsr_q;
	int          cycle_cnt = 0;
	int          value_errs = 0;
	int          proto_errs = 0;

	tb_clock_gen i_clock_gen (.clk_o(clk), .rst_o(rst));

	spi_flash_ctrl #(.SCK_DIV(8'd2), .RESET_WAIT(20)) i_spi_flash_ctrl (
		.clk, .rst, .cyc_i(cyc), .stb_i(stb), .we_i(we), .adr_i(adr), .dat_i(dat_w),
		.dat_o, .ack_o, .sck_o, .cs_n_o, .mosi_o, .miso_i
	);

	spi_flash_model i_flash_model (
		.sck_i(sck_o), .cs_n_i(cs_n_o), .mosi_i(mosi_o), .miso_o(miso_i),
		.reset_cnt_o(reset_cnt), .wren_viol_o(wren_viol), .busy_o(flash_busy)
	);

	// region 0 and region 1 writes reach the flash, nothing else does
	assign unmapped = cyc && stb && !(adr[25:24] == 2'd0 || (adr[25:24] == 2'd1 && we));

	//--------------------------------------------------------------------------
	// random source
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hD0000001) : (s >> 1);	// galois, right shift
	endfunction

	function automatic logic [31:0] draw_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v      = {v[30:0], lfsr_q[0]};	// one step per bit
			lfsr_q = lfsr_next(lfsr_q);
		end
		return v;
	endfunction

	function automatic flash_word_t expected_word(input flash_addr_t a);
		return {ref_mem[a[7:0] + 8'd3], ref_mem[a[7:0] + 8'd2],
			ref_mem[a[7:0] + 8'd1], ref_mem[a[7:0]]};	// low address in 7..0
	endfunction

	task automatic compare_word(input string name, input flash_word_t exp, input flash_word_t act);
		assert (act === exp)
			else begin
				value_errs++;
				$display("** Error at %0t: %s expected %08h, got %08h", $time, name, exp, act);
			end
	endtask

	//--------------------------------------------------------------------------
	// wishbone master, held until ack
	task automatic write_word(input logic [25:0] a, input flash_word_t d);
		@(posedge clk);
		cyc   <= 1'b1;
		stb   <= 1'b1;
		we    <= 1'b1;
		adr   <= a;
		dat_w <= d;
		do @(posedge clk); while (ack_o !== 1'b1);
		cyc <= 1'b0;
		stb <= 1'b0;
		we  <= 1'b0;
	endtask

	task automatic read_word(input logic [25:0] a, output flash_word_t d);
		@(posedge clk);
		cyc <= 1'b1;
		stb <= 1'b1;
		we  <= 1'b0;
		adr <= a;
		do @(posedge clk); while (ack_o !== 1'b1);
		d   = dat_o;	// registered, stable at this edge
		cyc <= 1'b0;
		stb <= 1'b0;
	endtask

	//--------------------------------------------------------------------------
	// protocol checks against the flash model
	reset_before_cmd: assert property (@(posedge clk) disable iff (rst)
		i_spi_flash_ctrl.cmd_valid |-> reset_cnt == 1)
		else begin
			proto_errs++;
			$display("** Error at %0t: reset_cnt expected 1, got %0d", $time, reset_cnt);
		end

	reset_before_ack: assert property (@(posedge clk) disable iff (rst)
		ack_o |-> reset_cnt == 1)
		else begin
			proto_errs++;
			$display("** Error at %0t: reset_cnt expected 1, got %0d", $time, reset_cnt);
		end

	ack_after_busy: assert property (@(posedge clk) disable iff (rst)
		ack_o |-> !flash_busy)
		else begin
			proto_errs++;
			$display("** Error at %0t: flash_busy expected 0, got 1", $time);
		end

	quiet_unmapped: assert property (@(posedge clk) disable iff (rst)
		unmapped |-> cs_n_o)
		else begin
			proto_errs++;
			$display("** Error at %0t: cs_n_o expected 1, got 0", $time);
		end

	initial begin : stimulus
		flash_addr_t a;
		flash_word_t w;
		flash_word_t rd;
		lfsr_q = LFSR_SEED;
		for (int k = 0; k < 256; k++) begin
			ref_mem[8'(k)]               = 8'(draw_bits(8));
			i_flash_model.mem[8'(k)] = ref_mem[8'(k)];
		end
		wait (rst === 1'b0);
		repeat (2) begin	// plain reads
			a = flash_addr_t'(draw_bits(24));
			read_word({2'b00, a}, rd);
			compare_word("dat_o", expected_word(a), rd);
		end
		repeat (2) begin	// program then read back
			a = flash_addr_t'(draw_bits(24));
			w = draw_bits(32);
			write_word({2'b00, a}, w);
			for (int k = 0; k < WORD_BYTES; k++)
				ref_mem[a[7:0] + 8'(k)] = w[8 * k +: 8];
			read_word({2'b00, a}, rd);
			compare_word("dat_o", expected_word(a), rd);
		end
		a = flash_addr_t'(draw_bits(24));
		write_word({2'b01, a}, 32'h0);	// sector erase
		for (int k = 0; k < 256; k++)
			ref_mem[8'(k)] = 8'hFF;
		repeat (2) begin
			a = flash_addr_t'(draw_bits(24));
			read_word({2'b00, a}, rd);
			compare_word("dat_o", 32'hFFFFFFFF, rd);
		end
		read_word({2'b11, flash_addr_t'(draw_bits(24))}, rd);	// dat_o still all ones here
		compare_word("dat_o", 32'h0, rd);	// unmapped reads give zero
		write_word({2'b10, flash_addr_t'(draw_bits(24))}, draw_bits(32));
		assert (reset_cnt == 1)
			else begin
				value_errs++;
				$display("** Error at %0t: reset_cnt expected 1, got %0d", $time, reset_cnt);
			end
		assert (wren_viol == 0)
			else begin
				value_errs++;
				$display("** Error at %0t: wren_viol expected 0, got %0d", $time, wren_viol);
			end
		$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
		if (value_errs + proto_errs == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// run limit
	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d value, %0d protocol", value_errs, proto_errs);
			$display("** FAIL **");
			$finish;
		end
	end

endmodule

/* spi_flash_ctrl.f */
rtl/flash_cmd_pkg.sv
rtl/spi_link_pkg.sv
rtl/wb_flash_slave.sv
rtl/flash_cmd_sequencer.sv
rtl/spi_byte_shifter.sv
rtl/spi_flash_ctrl.sv
sim/tb_clock_gen.sv
sim/spi_flash_model.sv
sim/spi_flash_ctrl_properties.sv
sim/tb_spi_flash_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SPI flash controller testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_spi_flash_ctrl \
	-Mdir obj_dir -o sim_tb \
	-f spi_flash_ctrl.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
	exit 1
fi
exit 0
